// File: decode_issue_tb.sv
/*
 * Testbench for the decode-and-issue front end. Streams random RV32 words
 * through the fetch handshake in rounds, acks packets with random delays
 * and checks every packet against a shadow register file and decode model.
 */
module decode_issue_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import uarch_pkg::*;

  localparam isa_subset_t SUBSET  = ISA_ALL & ~OP_MUL_VEC; // mul masked out
  localparam int          ROUNDS  = 4;
  localparam int          INSTS   = 40;  // per round
  localparam int          WRITES  = 12;  // writebacks per round
  localparam int          TIMEOUT = 200; // cycles per wait
  localparam int          TOTAL   = ROUNDS * INSTS;

  logic       clk;
  logic       reset;
  logic       in_req;
  word_t      in_inst;
  logic       in_ack;
  logic       out_req;
  issue_pkt_t out_pkt;
  logic       out_ack;
  logic       wb_en;
  reg_addr_t  wb_addr;
  word_t      wb_data;

  integer     seed     = 32'h3a5a_8c9c; // stimulus stream
  integer     ack_seed = 32'h3a5a_8c9c; // responder delays
  word_t      shadow [32];              // model register file
  issue_pkt_t exp_q [$];                // expected packets oldest first
  int         sent_count;
  int         recv_count;
  int         req_rises = 0;            // out_req rising edges seen by the monitor

  logic prev_in_req;
  logic prev_in_ack;
  logic prev_out_req;
  logic prev_out_ack;

  decode_issue_top #(
    .isa_subset (SUBSET)
  ) decode_issue_top_i (
    .clk     (clk),
    .reset   (reset),
    .in_req  (in_req),
    .in_inst (in_inst),
    .in_ack  (in_ack),
    .out_req (out_req),
    .out_pkt (out_pkt),
    .out_ack (out_ack),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  // ----------------------------------------
  // failure reporting and compares
  // ----------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_pkt(input string test, input issue_pkt_t exp, input issue_pkt_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s: expected %h, actual %h", test, exp, act));
    end
  endtask

  task automatic check_bit(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s: expected %b, actual %b", test, exp, act));
    end
  endtask

  task automatic check_count(input string test, input int exp, input int act);
    if (act != exp) begin
      abort_run($sformatf("ERROR %s: expected %0d, actual %0d", test, exp, act));
    end
  endtask

  // ----------------------------------------
  // reference model
  // ----------------------------------------

  function automatic word_t shadow_val(input reg_addr_t a);
    return (a == '0) ? '0 : shadow[a]; // x0 reads zero
  endfunction

  function automatic issue_pkt_t model_pkt(input word_t w);
    issue_pkt_t p;
    rv_uop      uop;
    jump_kind_t jump;
    word_t      imm;
    logic       legal;
    logic       use_rs1;
    logic       use_rs2;
    logic       writes;
    logic       has_imm;
    legal   = 1'b0;
    uop     = OP_ADD;
    jump    = J_NONE;
    use_rs1 = 1'b1;
    use_rs2 = 1'b0;
    writes  = 1'b1;
    has_imm = 1'b1;
    imm     = {{20{w[31]}}, w[31:20]}; // I format unless overridden
    case (w[6:0])
      7'b0110011: begin // reg-reg where only funct7 zero is add
        legal   = (w[14:12] == 3'b000) && (w[31:25] == 7'b0000000);
        use_rs2 = 1'b1;
        has_imm = 1'b0;
      end
      7'b0010011: legal = (w[14:12] == 3'b000); // addi
      7'b0000011: begin
        legal = (w[14:12] == 3'b010);
        uop   = OP_LW;
      end
      7'b0100011: begin
        legal   = (w[14:12] == 3'b010);
        uop     = OP_SW;
        use_rs2 = 1'b1;
        writes  = 1'b0;
        imm     = {{20{w[31]}}, w[31:25], w[11:7]};
      end
      7'b1101111: begin // jal reads nothing
        legal   = 1'b1;
        uop     = OP_JAL;
        jump    = J_JAL;
        use_rs1 = 1'b0;
        imm     = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      7'b1100111: begin
        legal = (w[14:12] == 3'b000);
        uop   = OP_JALR;
        jump  = J_JALR;
      end
      default: legal = 1'b0;
    endcase
    p = '0;
    if (!legal) begin
      p.illegal = 1'b1; // everything else stays zero
    end else begin
      p.uop        = uop;
      p.jump       = jump;
      p.wen        = writes;
      p.waddr      = writes ? w[11:7] : '0;
      p.op1        = use_rs1 ? shadow_val(w[19:15]) : '0;
      p.store_data = use_rs2 ? shadow_val(w[24:20]) : '0;
      p.imm        = has_imm ? imm : '0;
      p.op2        = has_imm ? imm : shadow_val(w[24:20]);
    end
    return p;
  endfunction

  // legal encodings of every op plus raw random words
  function automatic word_t rand_inst();
    word_t w;
    int    kind;
    w    = $random(seed);
    kind = $unsigned($random(seed)) % 8;
    case (kind)
      0: w = {7'b0000000, w[24:15], 3'b000, w[11:7], 7'b0110011}; // add
      1: w = {w[31:15], 3'b000, w[11:7], 7'b0010011};             // addi
      2: w = {w[31:15], 3'b010, w[11:7], 7'b0000011};             // lw
      3: w = {w[31:15], 3'b010, w[11:7], 7'b0100011};             // sw
      4: w = {w[31:7], 7'b1101111};                               // jal
      5: w = {w[31:15], 3'b000, w[11:7], 7'b1100111};             // jalr
      6: w = {7'b0000001, w[24:15], 3'b000, w[11:7], 7'b0110011}; // mul
      default: ;
    endcase
    return w;
  endfunction

  // ----------------------------------------
  // stimulus tasks start just after a rising edge
  // ----------------------------------------

  task automatic write_regs(input int count);
    int        i;
    reg_addr_t a;
    word_t     d;
    for (i = 0; i < count; i++) begin
      a = (i == 0) ? 5'd0 : reg_addr_t'($random(seed)); // first write hits x0
      d = $random(seed);
      wb_en   <= 1'b1;
      wb_addr <= a;
      wb_data <= d;
      if (a != '0) begin
        shadow[a] = d;
      end
      @(posedge clk);
    end
    wb_en <= 1'b0;
  endtask

  task automatic send_inst(input word_t w);
    int cnt;
    in_inst <= w;
    in_req  <= 1'b1;
    exp_q.push_back(model_pkt(w)); // operands fixed now since no writes are in flight
    sent_count++;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > TIMEOUT) abort_run("in_ack did not rise within 200 cycles");
    end while (in_ack !== 1'b1);
    in_req <= 1'b0;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > TIMEOUT) abort_run("in_ack did not fall within 200 cycles");
    end while (in_ack !== 1'b0);
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      cnt++;
      if (cnt >= TIMEOUT) abort_run("pipeline did not drain within 200 cycles");
    end
  endtask

  task automatic run_rounds();
    int r;
    int n;
    for (r = 0; r < ROUNDS; r++) begin
      wait_drain(); // writebacks only with nothing in flight
      write_regs(WRITES);
      for (n = 0; n < INSTS; n++) begin
        send_inst(rand_inst());
      end
    end
  endtask

  // execute-side responder acks each packet after 0 to 5 cycles
  task automatic respond();
    int         cnt;
    int         delay;
    issue_pkt_t exp;
    while (recv_count < TOTAL) begin
      cnt = 0;
      do begin
        @(posedge clk);
        cnt++;
        if (cnt > TIMEOUT) abort_run("out_req did not rise within 200 cycles");
      end while (out_req !== 1'b1);
      if (exp_q.size() == 0) abort_run("out_req raised with no instruction outstanding");
      exp = exp_q.pop_front();
      check_pkt($sformatf("packet %0d", recv_count), exp, out_pkt);
      recv_count++;
      delay = $unsigned($random(ack_seed)) % 6;
      repeat (delay) @(posedge clk);
      out_ack <= 1'b1;
      cnt = 0;
      do begin
        @(posedge clk);
        cnt++;
        if (cnt > TIMEOUT) abort_run("out_req did not fall within 200 cycles");
      end while (out_req !== 1'b0);
      out_ack <= 1'b0;
    end
  endtask

  // ----------------------------------------
  // protocol monitor
  // ----------------------------------------

  always @(posedge clk) begin
    if (!reset) begin
      if (in_ack && !prev_in_ack && !prev_in_req) abort_run("in_ack rose while in_req was low");
      if (!in_ack && prev_in_ack && prev_in_req) begin
        abort_run("in_ack fell while in_req was still high");
      end
      if (out_req && !prev_out_req && (prev_out_ack || out_ack)) begin
        abort_run("out_req raised again before out_ack fell");
      end
      if (!out_req && prev_out_req && !prev_out_ack) begin
        abort_run("out_req dropped before out_ack was raised");
      end
      if (out_req && !prev_out_req) begin
        req_rises++; // one per packet offered
      end
    end
    prev_in_req  <= in_req;
    prev_in_ack  <= in_ack;
    prev_out_req <= out_req;
    prev_out_ack <= out_ack;
  end

  initial begin
    reset      = 1'b1;
    in_req     = 1'b0;
    in_inst    = '0;
    out_ack    = 1'b0;
    wb_en      = 1'b0;
    wb_addr    = '0;
    wb_data    = '0;
    sent_count = 0;
    recv_count = 0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0; // matches reset of the register file
    end
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_bit("in_ack after reset", 1'b0, in_ack);
    check_bit("out_req after reset", 1'b0, out_req);
    fork
      run_rounds();
      respond();
    join
    repeat (20) @(posedge clk); // idle window to catch a trailing extra packet
    check_bit("out_req after last packet", 1'b0, out_req);
    check_count("packets issued", sent_count, req_rises);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: decode_issue_top.sv
/*
 * Decode-and-issue front end. Chains the fetch receiver, operand read
 * and execute sender; isa_subset selects the decodable ops.
 */
module decode_issue_top #(
  parameter uarch_pkg::isa_subset_t isa_subset = uarch_pkg::ISA_ALL
) (
  input  logic                  clk,
  input  logic                  reset,
  // fetch side
  input  logic                  in_req,
  input  uarch_pkg::word_t      in_inst,
  output logic                  in_ack,
  // execute side
  output logic                  out_req,
  output uarch_pkg::issue_pkt_t out_pkt,
  input  logic                  out_ack,
  // writeback port
  input  logic                  wb_en,
  input  uarch_pkg::reg_addr_t  wb_addr,
  input  uarch_pkg::word_t      wb_data
);

  import uarch_pkg::*;

  // ----------------------------------------
  // stage links
  // ----------------------------------------

  logic       dec_valid;
  logic       dec_ready;
  decoded_t   dec_bundle;
  logic       pkt_valid;
  logic       pkt_ready;
  issue_pkt_t pkt;

  decode_stage #(
    .isa_subset (isa_subset)
  ) decode_stage_i (
    .clk        (clk),
    .reset      (reset),
    .in_req     (in_req),
    .in_inst    (in_inst),
    .in_ack     (in_ack),
    .dec_valid  (dec_valid),
    .dec_bundle (dec_bundle),
    .dec_ready  (dec_ready)
  );

  operand_stage operand_stage_i (
    .clk        (clk),
    .reset      (reset),
    .dec_valid  (dec_valid),
    .dec_bundle (dec_bundle),
    .dec_ready  (dec_ready),
    .wb_en      (wb_en),
    .wb_addr    (wb_addr),
    .wb_data    (wb_data),
    .pkt_valid  (pkt_valid),
    .pkt        (pkt),
    .pkt_ready  (pkt_ready)
  );

  issue_tx issue_tx_i (
    .clk       (clk),
    .reset     (reset),
    .pkt_valid (pkt_valid),
    .pkt       (pkt),
    .pkt_ready (pkt_ready),
    .out_req   (out_req),
    .out_pkt   (out_pkt),
    .out_ack   (out_ack)
  );

endmodule

// File: decode_stage.sv
/*
 * Fetch-side four-phase receiver. Decodes the incoming word and holds the
 * result in a one-entry register, handed on with valid/ready.
 */
module decode_stage #(
  parameter uarch_pkg::isa_subset_t isa_subset = uarch_pkg::ISA_ALL
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                in_req,
  input  uarch_pkg::word_t    in_inst,
  output logic                in_ack,
  output logic                dec_valid,
  output uarch_pkg::decoded_t dec_bundle,
  input  logic                dec_ready
);

  import uarch_pkg::*;

  decoded_t dec_next; // decoder output for in_inst
  logic     drain;    // bundle leaves this cycle
  logic     take;     // capture in_inst this edge

  inst_decoder #(
    .isa_subset (isa_subset)
  ) inst_decoder_i (
    .inst (in_inst),
    .dec  (dec_next)
  );

  assign drain = dec_valid && dec_ready;
  // new request, not yet acked, room in the slot
  assign take  = in_req && !in_ack && (!dec_valid || drain);

  // ----------------------------------------
  // handshake control
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      in_ack    <= 1'b0;
      dec_valid <= 1'b0;
    end else begin
      if (take) begin
        in_ack <= 1'b1;
      end else if (!in_req) begin
        in_ack <= 1'b0; // return to zero phase
      end

      if (take) begin
        dec_valid <= 1'b1;
      end else if (drain) begin
        dec_valid <= 1'b0;
      end
    end
  end

  // payload only
  always_ff @(posedge clk) begin
    if (take) begin
      dec_bundle <= dec_next;
    end
  end

  // req still held in the cycle where ack goes high
  a_ack_follows_req: assert property (
    @(posedge clk) disable iff (reset)
    $rose(in_ack) |-> in_req
  ) else $error("in_ack rose while in_req was low");

endmodule

// File: inst_decoder.sv
/*
 * Combinational instruction decoder. Maps an RV32 word to linearized
 * control fields; ops outside the isa_subset mask decode as illegal.
 */
module inst_decoder #(
  parameter uarch_pkg::isa_subset_t isa_subset = uarch_pkg::ISA_ALL
) (
  input  uarch_pkg::word_t    inst,
  output uarch_pkg::decoded_t dec
);

  import uarch_pkg::*;

  // ----------------------------------------
  // instruction fields
  // ----------------------------------------

  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;

  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign rd  = inst[11:7];

  localparam reg_addr_t RX = 5'd0; // unused read port, reads x0

  localparam logic Y = 1'b1;
  localparam logic N = 1'b0;

  // packs one row of the control table
  function automatic decoded_t ctl(
    input rv_uop      uop,
    input jump_kind_t jump,
    input reg_addr_t  raddr0,
    input reg_addr_t  raddr1,
    input reg_addr_t  waddr,
    input logic       wen,
    input rv_imm_type imm_sel,
    input logic       op2_imm
  );
    decoded_t d;
    d         = '0;
    d.uop     = uop;
    d.jump    = jump;
    d.raddr0  = raddr0;
    d.raddr1  = raddr1;
    d.waddr   = waddr;
    d.wen     = wen;
    d.imm_sel = imm_sel;
    d.op2_imm = op2_imm;
    return d;
  endfunction

  // ----------------------------------------
  // control table
  // ----------------------------------------

  always_comb begin
    dec         = '0;
    dec.illegal = 1'b1; // anything unmatched

    // arithmetic
    if ((isa_subset & OP_ADD_VEC) != '0) begin
      casez (inst) //          uop      jump    r0   r1   wa  wen sel    op2imm
        INST_ADD:  dec = ctl(OP_ADD,  J_NONE, rs1, rs2, rd, Y, IMM_I, N);
        INST_ADDI: dec = ctl(OP_ADD,  J_NONE, rs1, RX,  rd, Y, IMM_I, Y);
        default: ;
      endcase
    end

    if ((isa_subset & OP_MUL_VEC) != '0) begin
      casez (inst)
        INST_MUL:  dec = ctl(OP_MUL,  J_NONE, rs1, rs2, rd, Y, IMM_I, N);
        default: ;
      endcase
    end

    // memory
    if ((isa_subset & OP_LW_VEC) != '0) begin
      casez (inst)
        INST_LW:   dec = ctl(OP_LW,   J_NONE, rs1, RX,  rd, Y, IMM_I, Y);
        default: ;
      endcase
    end

    if ((isa_subset & OP_SW_VEC) != '0) begin
      casez (inst) // no writeback, rs2 is the store data
        INST_SW:   dec = ctl(OP_SW,   J_NONE, rs1, rs2, RX, N, IMM_S, Y);
        default: ;
      endcase
    end

    // control flow, target computed downstream
    if ((isa_subset & OP_JAL_VEC) != '0) begin
      casez (inst)
        INST_JAL:  dec = ctl(OP_JAL,  J_JAL,  RX,  RX,  rd, Y, IMM_J, Y);
        default: ;
      endcase
    end

    if ((isa_subset & OP_JALR_VEC) != '0) begin
      casez (inst)
        INST_JALR: dec = ctl(OP_JALR, J_JALR, rs1, RX,  rd, Y, IMM_I, Y);
        default: ;
      endcase
    end

    // raw word only rides along with legal ops
    if (!dec.illegal) begin
      dec.inst = inst;
    end
  end

endmodule

// File: issue_tx.sv
/*
 * Execute-side four-phase sender. Takes one issue packet and holds it
 * on out_pkt through req, ack, release, before accepting the next.
 */
module issue_tx (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  pkt_valid,
  input  uarch_pkg::issue_pkt_t pkt,
  output logic                  pkt_ready,
  output logic                  out_req,
  output uarch_pkg::issue_pkt_t out_pkt,
  input  logic                  out_ack
);

  import uarch_pkg::*;

  typedef enum logic [1:0] {
    IDLE,         // slot free
    WAIT_ACK,     // req high
    WAIT_RELEASE  // req dropped, ack still high
  } state_t;

  state_t state;
  state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      IDLE:         if (pkt_valid) state_next = WAIT_ACK;
      WAIT_ACK:     if (out_ack)   state_next = WAIT_RELEASE;
      WAIT_RELEASE: if (!out_ack)  state_next = IDLE;
      default:      state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign pkt_ready = (state == IDLE);
  assign out_req   = (state == WAIT_ACK);

  always_ff @(posedge clk) begin
    if (pkt_valid && pkt_ready) begin
      out_pkt <= pkt; // held for the whole exchange
    end
  end

  a_pkt_stable: assert property (
    @(posedge clk) disable iff (reset)
    (out_req && $past(out_req)) |-> $stable(out_pkt)
  ) else $error("out_pkt changed while out_req was high");

  // next req waits for the receiver to drop ack
  a_req_after_release: assert property (
    @(posedge clk) disable iff (reset)
    $rose(out_req) |-> !out_ack
  ) else $error("out_req raised while out_ack still high");

endmodule

// File: operand_stage.sv
/*
 * Operand read stage. Reads the register file for the decoded bundle,
 * builds the immediate, picks op2 and registers the issue packet.
 */
module operand_stage (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  dec_valid,
  input  uarch_pkg::decoded_t   dec_bundle,
  output logic                  dec_ready,
  input  logic                  wb_en,
  input  uarch_pkg::reg_addr_t  wb_addr,
  input  uarch_pkg::word_t      wb_data,
  output logic                  pkt_valid,
  output uarch_pkg::issue_pkt_t pkt,
  input  logic                  pkt_ready
);

  import uarch_pkg::*;

  word_t      rdata0;
  word_t      rdata1;
  word_t      imm;
  issue_pkt_t pkt_next;
  logic       load;

  // writeback only happens with nothing in flight
  reg_file reg_file_i (
    .clk    (clk),
    .reset  (reset),
    .raddr0 (dec_bundle.raddr0),
    .raddr1 (dec_bundle.raddr1),
    .rdata0 (rdata0),
    .rdata1 (rdata1),
    .wen    (wb_en),
    .waddr  (wb_addr),
    .wdata  (wb_data)
  );

  // ----------------------------------------
  // immediate generation
  // ----------------------------------------

  function automatic word_t build_imm(input word_t inst, input rv_imm_type sel);
    word_t v;
    case (sel)
      IMM_I:   v = {{20{inst[31]}}, inst[31:20]};
      IMM_S:   v = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      IMM_J:   v = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default: v = '0;
    endcase
    return v;
  endfunction

  // reg-reg ops carry no immediate
  assign imm = dec_bundle.op2_imm ? build_imm(dec_bundle.inst, dec_bundle.imm_sel) : '0;

  always_comb begin
    pkt_next.illegal    = dec_bundle.illegal;
    pkt_next.uop        = dec_bundle.uop;
    pkt_next.jump       = dec_bundle.jump;
    pkt_next.waddr      = dec_bundle.waddr;
    pkt_next.wen        = dec_bundle.wen;
    pkt_next.op1        = rdata0;
    pkt_next.op2        = dec_bundle.op2_imm ? imm : rdata1;
    pkt_next.imm        = imm;
    pkt_next.store_data = rdata1; // sw data from rs2
  end

  // ----------------------------------------
  // one-entry packet slot
  // ----------------------------------------

  assign dec_ready = !pkt_valid || pkt_ready; // empty or draining
  assign load      = dec_valid && dec_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      pkt_valid <= 1'b0;
    end else if (load) begin
      pkt_valid <= 1'b1;
    end else if (pkt_ready) begin
      pkt_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      pkt <= pkt_next;
    end
  end

  // a stalled packet stays put until issue_tx takes it
  a_slot_held: assert property (
    @(posedge clk) disable iff (reset)
    (pkt_valid && !pkt_ready) |=> (pkt_valid && $stable(pkt))
  ) else $error("issue packet overwritten before it was taken");

endmodule

// File: reg_file.sv
/*
 * 32 x 32-bit register file, two combinational read ports and one
 * synchronous write port. x0 reads as zero and ignores writes.
 */
module reg_file (
  input  logic                clk,
  input  logic                reset,
  input  uarch_pkg::reg_addr_t raddr0,
  input  uarch_pkg::reg_addr_t raddr1,
  output uarch_pkg::word_t    rdata0,
  output uarch_pkg::word_t    rdata1,
  input  logic                wen,
  input  uarch_pkg::reg_addr_t waddr,
  input  uarch_pkg::word_t    wdata
);

  import uarch_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata; // x0 write dropped
    end
  end

  // read ports, x0 forced
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

// File: sim.f
uarch_pkg.sv
inst_decoder.sv
decode_stage.sv
reg_file.sv
operand_stage.sv
issue_tx.sv
decode_issue_top.sv
decode_issue_tb.sv

// File: uarch_pkg.sv
/*
 * Shared types for the decode-and-issue front end: micro-op and immediate
 * encodings, ISA subset mask bits, instruction match patterns and the
 * packed bundles passed between pipeline stages.
 */
package uarch_pkg;

  // ----------------------------------------
  // basic widths
  // ----------------------------------------

  typedef logic [31:0] word_t;     // data or instruction word
  typedef logic [4:0]  reg_addr_t; // architectural register index

  // ----------------------------------------
  // linearized control encodings
  // ----------------------------------------

  // zero value of each enum is what an illegal packet carries
  typedef enum logic [2:0] {
    OP_ADD,
    OP_MUL,
    OP_LW,
    OP_SW,
    OP_JAL,
    OP_JALR
  } rv_uop;

  typedef enum logic [1:0] {
    IMM_I,
    IMM_S,
    IMM_J
  } rv_imm_type;

  typedef enum logic [1:0] {
    J_NONE,
    J_JAL,
    J_JALR
  } jump_kind_t;

  // one bit per decodable op
  typedef logic [5:0] isa_subset_t;

  localparam isa_subset_t OP_ADD_VEC  = 6'b000001; // add + addi
  localparam isa_subset_t OP_MUL_VEC  = 6'b000010;
  localparam isa_subset_t OP_LW_VEC   = 6'b000100;
  localparam isa_subset_t OP_SW_VEC   = 6'b001000;
  localparam isa_subset_t OP_JAL_VEC  = 6'b010000;
  localparam isa_subset_t OP_JALR_VEC = 6'b100000;
  localparam isa_subset_t ISA_ALL     = 6'b111111;

  // ----------------------------------------
  // match patterns, ? bits are wildcards for casez
  // ----------------------------------------

  localparam word_t INST_ADD  = 32'b0000000_?????_?????_000_?????_0110011;
  localparam word_t INST_ADDI = 32'b????????????_?????_000_?????_0010011;
  localparam word_t INST_MUL  = 32'b0000001_?????_?????_000_?????_0110011;
  localparam word_t INST_LW   = 32'b????????????_?????_010_?????_0000011;
  localparam word_t INST_SW   = 32'b???????_?????_?????_010_?????_0100011;
  localparam word_t INST_JAL  = 32'b????????????????????_?????_1101111;
  localparam word_t INST_JALR = 32'b????????????_?????_000_?????_1100111;

  // ----------------------------------------
  // stage bundles
  // ----------------------------------------

  // decode -> operand read
  typedef struct packed {
    logic       illegal;
    rv_uop      uop;
    jump_kind_t jump;
    reg_addr_t  raddr0;
    reg_addr_t  raddr1;
    reg_addr_t  waddr;
    logic       wen;
    rv_imm_type imm_sel;
    logic       op2_imm;  // op2 takes the immediate
    word_t      inst;     // raw word, immediate built later
  } decoded_t;

  // operand read -> execute
  typedef struct packed {
    logic       illegal;
    rv_uop      uop;
    jump_kind_t jump;
    reg_addr_t  waddr;
    logic       wen;
    word_t      op1;
    word_t      op2;
    word_t      imm;
    word_t      store_data;
  } issue_pkt_t;

endpackage
